//--- ldqPkg.sv
`default_nettype none

package ldqPkg;

  // field widths of a load queue access
  localparam int ADDR_W = 16;
  localparam int BANK_W = 32;
  localparam int BYTE_LOW_W = 4;
  localparam int HALF_W = 4;
  localparam int IDX_W = 10;

  // bit positions inside the half flags, OH on top
  localparam int HALF_OH = 3;
  localparam int HALF_EH = 2;
  localparam int HALF_OL = 1;
  localparam int HALF_EL = 0;

  // default queue depth
  localparam int LDQ_ENTRIES = 8;

  // even or odd half-line address
  typedef logic [ADDR_W-1:0] ldqAddrT;

  // low 16 bits are the L half, high 16 bits the H half
  typedef logic [BANK_W-1:0] ldqBankT;

  typedef logic [BYTE_LOW_W-1:0] ldqByteLowT;

  // OH, EH, OL, EL
  typedef logic [HALF_W-1:0] ldqHalfT;

  // instruction index used by retire
  typedef logic [IDX_W-1:0] ldqIdxT;

endpackage

`default_nettype wire

//--- ldqCheckIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ldqCheckIf;
  import ldqPkg::*;

  ldqAddrT addrE;
  ldqAddrT addrO;
  ldqBankT banks;
  ldqByteLowT byteLow;
  ldqHalfT halves;
  // one-cycle level, no handshake
  logic valid;

  modport source (
    output addrE, addrO, banks, byteLow, halves, valid
  );

  modport sink (
    input addrE, addrO, banks, byteLow, halves, valid
  );

endinterface

`default_nettype wire

//--- ldqConflict.sv
`timescale 1ns/1ps
`default_nettype none

module ldqConflict (
  input  ldqPkg::ldqAddrT    loadAddrE,
  input  ldqPkg::ldqAddrT    loadAddrO,
  input  ldqPkg::ldqBankT    loadBanks,
  input  ldqPkg::ldqByteLowT loadByteLow,
  input  ldqPkg::ldqHalfT    loadHalves,
  input  ldqPkg::ldqAddrT    chkAddrE,
  input  ldqPkg::ldqAddrT    chkAddrO,
  input  ldqPkg::ldqBankT    chkBanks,
  input  ldqPkg::ldqByteLowT chkByteLow,
  input  ldqPkg::ldqHalfT    chkHalves,
  output logic               hit
);
  import ldqPkg::*;

  localparam int HALF_BANKS = BANK_W / 2;

  logic byteHit;
  logic matchE;
  logic matchO;
  logic bankL;
  logic bankH;

  assign byteHit = |(loadByteLow & chkByteLow);
  assign matchE = (loadAddrE == chkAddrE);
  assign matchO = (loadAddrO == chkAddrO);
  assign bankL = |(loadBanks[HALF_BANKS-1:0] & chkBanks[HALF_BANKS-1:0]);
  assign bankH = |(loadBanks[BANK_W-1:HALF_BANKS] & chkBanks[BANK_W-1:HALF_BANKS]);

  // any one half overlapping is enough, byte lanes must always overlap
  assign hit = byteHit && (
    (loadHalves[HALF_OH] && chkHalves[HALF_OH] && matchO && bankH) ||
    (loadHalves[HALF_OL] && chkHalves[HALF_OL] && matchO && bankL) ||
    (loadHalves[HALF_EH] && chkHalves[HALF_EH] && matchE && bankH) ||
    (loadHalves[HALF_EL] && chkHalves[HALF_EL] && matchE && bankL));

endmodule

`default_nettype wire

//--- ldqEntry.sv
`timescale 1ns/1ps
`default_nettype none

module ldqEntry (
  input  logic               clk,
  input  logic               rst,
  input  logic               except,
  input  logic               exceptThread,
  input  logic               alloc,
  input  logic               allocConfl,
  input  ldqPkg::ldqAddrT    newAddrE,
  input  ldqPkg::ldqAddrT    newAddrO,
  input  ldqPkg::ldqBankT    newBanks,
  input  ldqPkg::ldqByteLowT newByteLow,
  input  ldqPkg::ldqHalfT    newHalves,
  input  ldqPkg::ldqIdxT     newIdx,
  input  logic               newThread,
  ldqCheckIf.sink            chk,
  input  logic               retireEn,
  input  ldqPkg::ldqIdxT     retireIdx,
  input  logic               retireStall,
  output logic               retireConfl,
  output logic               free
);
  import ldqPkg::*;

  logic live;
  logic confl;
  ldqAddrT addrE;
  ldqAddrT addrO;
  ldqBankT banks;
  ldqByteLowT byteLow;
  ldqHalfT halves;
  ldqIdxT idx;
  logic thread;

  logic chkHit;
  logic idxHit;
  logic flush;

  ldqConflict conflict_i (
    .loadAddrE   (addrE),
    .loadAddrO   (addrO),
    .loadBanks   (banks),
    .loadByteLow (byteLow),
    .loadHalves  (halves),
    .chkAddrE    (chk.addrE),
    .chkAddrO    (chk.addrO),
    .chkBanks    (chk.banks),
    .chkByteLow  (chk.byteLow),
    .chkHalves   (chk.halves),
    .hit         (chkHit)
  );

  assign idxHit = live && (retireIdx == idx);
  assign retireConfl = retireEn && idxHit && confl;
  assign free = !live;

  // a load arriving with the flushed thread is dropped as well
  assign flush = except && (alloc ? (exceptThread == newThread)
                                  : (live && (exceptThread == thread)));

  always_ff @(posedge clk) begin
    if (rst) begin
      live <= 1'b0;
      confl <= 1'b0;
    end else if (flush) begin
      live <= 1'b0;
    end else if (alloc) begin
      live <= 1'b1;
      confl <= allocConfl;
    end else if (live) begin
      if (chk.valid && chkHit) begin
        confl <= 1'b1;
      end
      // stalled retire still answers but keeps the entry
      if (retireEn && idxHit && !retireStall) begin
        live <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      addrE <= newAddrE;
      addrO <= newAddrO;
      banks <= newBanks;
      byteLow <= newByteLow;
      halves <= newHalves;
      idx <= newIdx;
      thread <= newThread;
    end
  end

endmodule

`default_nettype wire

//--- ldqArray.sv
`timescale 1ns/1ps
`default_nettype none

module ldqArray #(
  parameter int ENTRY_COUNT = ldqPkg::LDQ_ENTRIES
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               except,
  input  logic               exceptThread,
  input  logic               newEn,
  input  logic               newConfl,
  input  ldqPkg::ldqAddrT    newAddrE,
  input  ldqPkg::ldqAddrT    newAddrO,
  input  ldqPkg::ldqBankT    newBanks,
  input  ldqPkg::ldqByteLowT newByteLow,
  input  ldqPkg::ldqHalfT    newHalves,
  input  ldqPkg::ldqIdxT     newIdx,
  input  logic               newThread,
  ldqCheckIf.sink            chk,
  input  logic               retireEn,
  input  ldqPkg::ldqIdxT     retireIdx,
  input  logic               retireStall,
  output logic               retireConfl,
  output logic               full
);

  logic [ENTRY_COUNT-1:0] freeVec;
  logic [ENTRY_COUNT-1:0] lowestFree;
  logic [ENTRY_COUNT-1:0] allocVec;
  logic [ENTRY_COUNT-1:0] conflVec;

  // keep only the lowest set bit, zero when nothing is free
  assign lowestFree = freeVec & ((~freeVec) + ENTRY_COUNT'(1));
  assign allocVec = lowestFree & {ENTRY_COUNT{newEn}};

  for (genvar i = 0; i < ENTRY_COUNT; i++) begin : genEntry
    ldqEntry entry_i (
      .clk          (clk),
      .rst          (rst),
      .except       (except),
      .exceptThread (exceptThread),
      .alloc        (allocVec[i]),
      .allocConfl   (newConfl),
      .newAddrE     (newAddrE),
      .newAddrO     (newAddrO),
      .newBanks     (newBanks),
      .newByteLow   (newByteLow),
      .newHalves    (newHalves),
      .newIdx       (newIdx),
      .newThread    (newThread),
      .chk          (chk),
      .retireEn     (retireEn),
      .retireIdx    (retireIdx),
      .retireStall  (retireStall),
      .retireConfl  (conflVec[i]),
      .free         (freeVec[i])
    );
  end

  // at most one entry holds a given index
  assign retireConfl = |conflVec;
  assign full = ~|freeVec;

endmodule

`default_nettype wire

//--- ldq.sv
`timescale 1ns/1ps
`default_nettype none

module ldq #(
  parameter int ENTRY_COUNT = ldqPkg::LDQ_ENTRIES
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               except,
  input  logic               exceptThread,
  input  logic               newEn,
  input  ldqPkg::ldqAddrT    newAddrE,
  input  ldqPkg::ldqAddrT    newAddrO,
  input  ldqPkg::ldqBankT    newBanks,
  input  ldqPkg::ldqByteLowT newByteLow,
  input  ldqPkg::ldqHalfT    newHalves,
  input  ldqPkg::ldqIdxT     newIdx,
  input  logic               newThread,
  input  logic               chkEn,
  input  ldqPkg::ldqAddrT    chkAddrE,
  input  ldqPkg::ldqAddrT    chkAddrO,
  input  ldqPkg::ldqBankT    chkBanks,
  input  ldqPkg::ldqByteLowT chkByteLow,
  input  ldqPkg::ldqHalfT    chkHalves,
  input  logic               retireEn,
  input  ldqPkg::ldqIdxT     retireIdx,
  input  logic               retireStall,
  output logic               retireConfl,
  output logic               full
);

  ldqCheckIf chk_i ();

  logic newHit;
  logic newConfl;

  // store check register stage
  always_ff @(posedge clk) begin
    if (rst) begin
      chk_i.valid <= 1'b0;
    end else begin
      chk_i.valid <= chkEn;
    end
  end

  always_ff @(posedge clk) begin
    if (chkEn) begin
      chk_i.addrE <= chkAddrE;
      chk_i.addrO <= chkAddrO;
      chk_i.banks <= chkBanks;
      chk_i.byteLow <= chkByteLow;
      chk_i.halves <= chkHalves;
    end
  end

  // a load written this cycle misses the per-entry compare, so test it here
  ldqConflict conflict_i (
    .loadAddrE   (newAddrE),
    .loadAddrO   (newAddrO),
    .loadBanks   (newBanks),
    .loadByteLow (newByteLow),
    .loadHalves  (newHalves),
    .chkAddrE    (chk_i.addrE),
    .chkAddrO    (chk_i.addrO),
    .chkBanks    (chk_i.banks),
    .chkByteLow  (chk_i.byteLow),
    .chkHalves   (chk_i.halves),
    .hit         (newHit)
  );

  assign newConfl = newHit && chk_i.valid;

  ldqArray #(
    .ENTRY_COUNT (ENTRY_COUNT)
  ) array_i (
    .clk          (clk),
    .rst          (rst),
    .except       (except),
    .exceptThread (exceptThread),
    .newEn        (newEn),
    .newConfl     (newConfl),
    .newAddrE     (newAddrE),
    .newAddrO     (newAddrO),
    .newBanks     (newBanks),
    .newByteLow   (newByteLow),
    .newHalves    (newHalves),
    .newIdx       (newIdx),
    .newThread    (newThread),
    .chk          (chk_i.sink),
    .retireEn     (retireEn),
    .retireIdx    (retireIdx),
    .retireStall  (retireStall),
    .retireConfl  (retireConfl),
    .full         (full)
  );

endmodule

`default_nettype wire

//--- ldqAssert_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ldqAssert_chk (
  input logic clk,
  input logic rst,
  input logic newEn,
  input logic retireEn,
  input logic retireStall,
  input logic retireConfl,
  input logic full
);

  int failCount = 0;

  // reset frees every entry
  assert property (@(posedge clk) rst |=> !full)
    else begin
      failCount++;
      $error("full is high in the cycle after reset");
    end

  assert property (@(posedge clk) disable iff (rst) !retireEn |-> !retireConfl)
    else begin
      failCount++;
      $error("retireConfl is high without retireEn");
    end

  // a retire can only free an entry
  assert property (@(posedge clk) disable iff (rst)
      (retireEn && !retireStall && !newEn) |=> !$rose(full))
    else begin
      failCount++;
      $error("full rose after an unstalled retire with no allocation");
    end

endmodule

`default_nettype wire

//--- ldqScoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module ldqScoreboard (
  input  logic clk,
  input  logic active,
  input  int   stepNum,
  input  logic expConfl,
  input  logic expFull,
  input  logic retireConfl,
  input  logic full,
  output int   checkCount,
  output int   errorCount
);

  int checks = 0;
  int errors = 0;

  assign checkCount = checks;
  assign errorCount = errors;

  // outputs are stable here, inputs change on the falling edge
  always @(posedge clk) begin
    if (active) begin
      checks = checks + 2;
      if (retireConfl !== expConfl) begin
        errors = errors + 1;
        $display("CHECK FAILED step %0d: retireConfl = 0x%0h, expected 0x%0h",
                 stepNum, retireConfl, expConfl);
      end
      if (full !== expFull) begin
        errors = errors + 1;
        $display("CHECK FAILED step %0d: full = 0x%0h, expected 0x%0h",
                 stepNum, full, expFull);
      end
    end
  end

endmodule

`default_nettype wire

//--- ldqTb.sv
`timescale 1ns/1ps
`default_nettype none

module ldqTb;
  import ldqPkg::*;

  typedef struct packed {
    logic [3:0] test;
    logic newEn;
    ldqAddrT newAddrE;
    ldqAddrT newAddrO;
    ldqBankT newBanks;
    ldqByteLowT newByteLow;
    ldqHalfT newHalves;
    ldqIdxT newIdx;
    logic newThread;
    logic chkEn;
    ldqAddrT chkAddrE;
    ldqAddrT chkAddrO;
    ldqBankT chkBanks;
    ldqByteLowT chkByteLow;
    ldqHalfT chkHalves;
    logic retireEn;
    ldqIdxT retireIdx;
    logic retireStall;
    logic except;
    logic exceptThread;
    logic expConfl;
    logic expFull;
  } stepT;

  logic clk = 1'b0;
  logic rst;
  logic except;
  logic exceptThread;
  logic newEn;
  ldqAddrT newAddrE;
  ldqAddrT newAddrO;
  ldqBankT newBanks;
  ldqByteLowT newByteLow;
  ldqHalfT newHalves;
  ldqIdxT newIdx;
  logic newThread;
  logic chkEn;
  ldqAddrT chkAddrE;
  ldqAddrT chkAddrO;
  ldqBankT chkBanks;
  ldqByteLowT chkByteLow;
  ldqHalfT chkHalves;
  logic retireEn;
  ldqIdxT retireIdx;
  logic retireStall;
  logic retireConfl;
  logic full;

  logic active;
  logic expConfl;
  logic expFull;
  int stepNum;
  int checkCount;
  int errorCount;
  int errorsBefore = 0;
  int testsDone = 0;
  int cycleCount = 0;

  stepT tbl[$];
  // occupancy model used to work out the expected full flag
  ldqIdxT liveIdx[$];
  logic liveThread[$];

  always #5 clk = ~clk;

  ldq #(
    .ENTRY_COUNT (LDQ_ENTRIES)
  ) ldq_i (
    .clk          (clk),
    .rst          (rst),
    .except       (except),
    .exceptThread (exceptThread),
    .newEn        (newEn),
    .newAddrE     (newAddrE),
    .newAddrO     (newAddrO),
    .newBanks     (newBanks),
    .newByteLow   (newByteLow),
    .newHalves    (newHalves),
    .newIdx       (newIdx),
    .newThread    (newThread),
    .chkEn        (chkEn),
    .chkAddrE     (chkAddrE),
    .chkAddrO     (chkAddrO),
    .chkBanks     (chkBanks),
    .chkByteLow   (chkByteLow),
    .chkHalves    (chkHalves),
    .retireEn     (retireEn),
    .retireIdx    (retireIdx),
    .retireStall  (retireStall),
    .retireConfl  (retireConfl),
    .full         (full)
  );

  ldqScoreboard scoreboard_i (
    .clk         (clk),
    .active      (active),
    .stepNum     (stepNum),
    .expConfl    (expConfl),
    .expFull     (expFull),
    .retireConfl (retireConfl),
    .full        (full),
    .checkCount  (checkCount),
    .errorCount  (errorCount)
  );

  bind ldq ldqAssert_chk assert_i (
    .clk         (clk),
    .rst         (rst),
    .newEn       (newEn),
    .retireEn    (retireEn),
    .retireStall (retireStall),
    .retireConfl (retireConfl),
    .full        (full)
  );

  function automatic ldqAddrT randAddr();
    return ldqAddrT'($urandom);
  endfunction

  // enables low, addresses are don't-care
  function automatic stepT idleStep(input logic [3:0] test);
    stepT s;
    s = '0;
    s.test = test;
    s.newAddrE = randAddr();
    s.newAddrO = randAddr();
    s.chkAddrE = randAddr();
    s.chkAddrO = randAddr();
    return s;
  endfunction

  function automatic stepT loadStep(input logic [3:0] test, input ldqAddrT addrE,
                                    input ldqAddrT addrO, input ldqBankT banks,
                                    input ldqByteLowT byteLow, input ldqHalfT halves,
                                    input ldqIdxT idx, input logic thread);
    stepT s;
    s = idleStep(test);
    s.newEn = 1'b1;
    s.newAddrE = addrE;
    s.newAddrO = addrO;
    s.newBanks = banks;
    s.newByteLow = byteLow;
    s.newHalves = halves;
    s.newIdx = idx;
    s.newThread = thread;
    return s;
  endfunction

  function automatic stepT storeStep(input logic [3:0] test, input ldqAddrT addrE,
                                     input ldqAddrT addrO, input ldqBankT banks,
                                     input ldqByteLowT byteLow, input ldqHalfT halves);
    stepT s;
    s = idleStep(test);
    s.chkEn = 1'b1;
    s.chkAddrE = addrE;
    s.chkAddrO = addrO;
    s.chkBanks = banks;
    s.chkByteLow = byteLow;
    s.chkHalves = halves;
    return s;
  endfunction

  function automatic stepT retireStep(input logic [3:0] test, input ldqIdxT idx,
                                      input logic stall, input logic confl);
    stepT s;
    s = idleStep(test);
    s.retireEn = 1'b1;
    s.retireIdx = idx;
    s.retireStall = stall;
    s.expConfl = confl;
    return s;
  endfunction

  function automatic stepT flushStep(input logic [3:0] test, input logic thread);
    stepT s;
    s = idleStep(test);
    s.except = 1'b1;
    s.exceptThread = thread;
    return s;
  endfunction

  function automatic string testName(input logic [3:0] t);
    case (t)
      4'd1: return "disjoint loads";
      4'd2: return "same-half conflict";
      4'd3: return "same-cycle check";
      4'd4: return "full and free";
      4'd5: return "retire stall";
      4'd6: return "exception flush";
      default: return "unknown";
    endcase
  endfunction

  // full seen in a step reflects the state left by the steps before it
  task automatic pushStep(input stepT s);
    stepT t;
    int k;
    logic done;
    t = s;
    t.expFull = (liveIdx.size() == LDQ_ENTRIES);
    done = 1'b0;
    if (s.except) begin
      for (k = liveIdx.size() - 1; k >= 0; k--) begin
        if (liveThread[k] == s.exceptThread) begin
          liveIdx.delete(k);
          liveThread.delete(k);
        end
      end
    end else if (s.newEn && !t.expFull) begin
      liveIdx.push_back(s.newIdx);
      liveThread.push_back(s.newThread);
    end
    if (s.retireEn && !s.retireStall) begin
      for (k = 0; k < liveIdx.size(); k++) begin
        if (!done && liveIdx[k] == s.retireIdx) begin
          liveIdx.delete(k);
          liveThread.delete(k);
          done = 1'b1;
        end
      end
    end
    tbl.push_back(t);
  endtask

  task automatic buildTable();
    int i;
    for (i = 1; i <= 3; i++) begin
      pushStep(loadStep(4'd1, ldqAddrT'(i * 16'h1000), ldqAddrT'(i * 16'h1000 + 1),
                        32'h0001_0001, 4'hf, 4'hf, ldqIdxT'(i), 1'b0));
    end
    pushStep(storeStep(4'd1, 16'h4000, 16'h4001, 32'hffff_ffff, 4'hf, 4'hf));
    pushStep(idleStep(4'd1));
    for (i = 1; i <= 3; i++) begin
      pushStep(retireStep(4'd1, ldqIdxT'(i), 1'b0, 1'b0));
    end

    // OH only, so the even address is free to vary
    pushStep(loadStep(4'd2, randAddr(), 16'h0555, 32'h0003_0000, 4'b0011, 4'b1000,
                      10'h010, 1'b0));
    pushStep(loadStep(4'd2, randAddr(), 16'h0666, 32'h0003_0000, 4'b0011, 4'b1000,
                      10'h011, 1'b0));
    pushStep(loadStep(4'd2, randAddr(), 16'h0555, 32'h0001_0000, 4'b0011, 4'b1000,
                      10'h012, 1'b0));
    pushStep(loadStep(4'd2, randAddr(), 16'h0555, 32'h0003_0000, 4'b1100, 4'b1000,
                      10'h013, 1'b0));
    pushStep(storeStep(4'd2, randAddr(), 16'h0555, 32'h0002_0000, 4'b0010, 4'b1000));
    pushStep(idleStep(4'd2));
    pushStep(retireStep(4'd2, 10'h010, 1'b0, 1'b1));
    pushStep(retireStep(4'd2, 10'h011, 1'b0, 1'b0));
    pushStep(retireStep(4'd2, 10'h012, 1'b0, 1'b0));
    pushStep(retireStep(4'd2, 10'h013, 1'b0, 1'b0));

    pushStep(storeStep(4'd3, randAddr(), 16'h0777, 32'h0000_00f0, 4'b0001, 4'b0010));
    pushStep(loadStep(4'd3, randAddr(), 16'h0777, 32'h0000_0010, 4'b0001, 4'b0010,
                      10'h020, 1'b0));
    pushStep(loadStep(4'd3, randAddr(), 16'h0777, 32'h0000_0010, 4'b0001, 4'b0010,
                      10'h021, 1'b0));
    pushStep(retireStep(4'd3, 10'h020, 1'b0, 1'b1));
    pushStep(retireStep(4'd3, 10'h021, 1'b0, 1'b0));

    for (i = 0; i < LDQ_ENTRIES; i++) begin
      pushStep(loadStep(4'd4, ldqAddrT'(16'h0a00 + i), randAddr(), 32'h0000_0001,
                        4'b0001, 4'b0001, ldqIdxT'(10'h030 + i), 1'b0));
    end
    pushStep(idleStep(4'd4));
    // ignored while full
    pushStep(loadStep(4'd4, 16'h0aff, randAddr(), 32'h0000_0001, 4'b0001, 4'b0001,
                      10'h03f, 1'b0));
    pushStep(retireStep(4'd4, 10'h030, 1'b0, 1'b0));
    pushStep(loadStep(4'd4, 16'h0a08, randAddr(), 32'h0000_0001, 4'b0001, 4'b0001,
                      10'h038, 1'b0));
    pushStep(idleStep(4'd4));
    pushStep(retireStep(4'd4, 10'h03f, 1'b0, 1'b0));

    pushStep(storeStep(4'd5, 16'h0a03, randAddr(), 32'h0000_0001, 4'b0001, 4'b0001));
    pushStep(idleStep(4'd5));
    pushStep(retireStep(4'd5, 10'h033, 1'b1, 1'b1));
    pushStep(retireStep(4'd5, 10'h033, 1'b0, 1'b1));
    pushStep(idleStep(4'd5));
    pushStep(retireStep(4'd5, 10'h033, 1'b0, 1'b0));
    pushStep(flushStep(4'd5, 1'b0));
    pushStep(idleStep(4'd5));

    for (i = 0; i < LDQ_ENTRIES; i++) begin
      pushStep(loadStep(4'd6, ldqAddrT'(16'h0b00 + i), randAddr(), 32'h0001_0000,
                        4'b0010, 4'b0100, ldqIdxT'(10'h040 + i), i[0]));
    end
    pushStep(storeStep(4'd6, 16'h0b01, randAddr(), 32'h0001_0000, 4'b0010, 4'b0100));
    pushStep(idleStep(4'd6));
    pushStep(retireStep(4'd6, 10'h041, 1'b1, 1'b1));
    pushStep(flushStep(4'd6, 1'b1));
    pushStep(retireStep(4'd6, 10'h041, 1'b0, 1'b0));
    pushStep(retireStep(4'd6, 10'h040, 1'b0, 1'b0));
    pushStep(flushStep(4'd6, 1'b0));
    pushStep(idleStep(4'd6));
  endtask

  task automatic applyStep(input stepT s, input int n);
    newEn = s.newEn;
    newAddrE = s.newAddrE;
    newAddrO = s.newAddrO;
    newBanks = s.newBanks;
    newByteLow = s.newByteLow;
    newHalves = s.newHalves;
    newIdx = s.newIdx;
    newThread = s.newThread;
    chkEn = s.chkEn;
    chkAddrE = s.chkAddrE;
    chkAddrO = s.chkAddrO;
    chkBanks = s.chkBanks;
    chkByteLow = s.chkByteLow;
    chkHalves = s.chkHalves;
    retireEn = s.retireEn;
    retireIdx = s.retireIdx;
    retireStall = s.retireStall;
    except = s.except;
    exceptThread = s.exceptThread;
    expConfl = s.expConfl;
    expFull = s.expFull;
    stepNum = n;
  endtask

  task automatic reportTest(input logic [3:0] t);
    int errs;
    errs = errorCount - errorsBefore;
    if (errs == 0) begin
      $display("test %0d (%s): ok", t, testName(t));
    end else begin
      $display("test %0d (%s): %0d errors", t, testName(t), errs);
    end
    errorsBefore = errorCount;
    testsDone++;
  endtask

  // run length is reset plus one cycle per step, so twice that is ample
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= 2 * tbl.size() + 50) begin
      $display("timeout: run did not finish within %0d cycles", cycleCount);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int i;
    void'($urandom(21679));
    buildTable();
    active = 1'b0;
    rst = 1'b1;
    applyStep(idleStep(4'd0), 0);
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (i = 0; i < tbl.size(); i++) begin
      @(negedge clk);
      if (i > 0 && tbl[i].test != tbl[i-1].test) begin
        reportTest(tbl[i-1].test);
      end
      applyStep(tbl[i], i);
      active = 1'b1;
    end
    @(negedge clk);
    active = 1'b0;
    applyStep(idleStep(4'd0), 0);
    reportTest(tbl[tbl.size()-1].test);
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", testsDone,
             checkCount, errorCount, ldq_i.assert_i.failCount);
    if (errorCount == 0 && ldq_i.assert_i.failCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
ldqPkg.sv
ldqCheckIf.sv
ldqConflict.sv
ldqEntry.sv
ldqArray.sv
ldq.sv
ldqAssert_chk.sv
ldqScoreboard.sv
ldqTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module ldqTb -o ldqSim

# the simulator status is not trusted, the log decides
./obj_dir/ldqSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
exit 1
